// ==== common/id_pkg.sv ====
`default_nettype none

package id_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ = 5'b00000,
        RI_BGEZ = 5'b00001
    } regimm_e;

    // Codes follow the instruction fields: 11+funct, 01+opcode, 100+rt
    typedef enum logic [7:0] {
        ALU_NOP   = 8'h00,
        ALU_SLL   = 8'hC0, ALU_SRL   = 8'hC2, ALU_SRA   = 8'hC3,
        ALU_SLLV  = 8'hC4, ALU_SRLV  = 8'hC6, ALU_SRAV  = 8'hC7,
        ALU_JR    = 8'hC8, ALU_JALR  = 8'hC9,
        ALU_ADD   = 8'hE0, ALU_ADDU  = 8'hE1, ALU_SUB   = 8'hE2, ALU_SUBU = 8'hE3,
        ALU_AND   = 8'hE4, ALU_OR    = 8'hE5, ALU_XOR   = 8'hE6, ALU_NOR  = 8'hE7,
        ALU_SLT   = 8'hEA, ALU_SLTU  = 8'hEB,
        ALU_J     = 8'h42, ALU_JAL   = 8'h43, ALU_BEQ   = 8'h44, ALU_BNE  = 8'h45,
        ALU_BLEZ  = 8'h46, ALU_BGTZ  = 8'h47,
        ALU_ADDI  = 8'h48, ALU_ADDIU = 8'h49, ALU_SLTI  = 8'h4A, ALU_SLTIU = 8'h4B,
        ALU_ANDI  = 8'h4C, ALU_ORI   = 8'h4D, ALU_XORI  = 8'h4E, ALU_LUI  = 8'h4F,
        ALU_LB    = 8'h60, ALU_LH    = 8'h61, ALU_LW    = 8'h63,
        ALU_LBU   = 8'h64, ALU_LHU   = 8'h65,
        ALU_SB    = 8'h68, ALU_SH    = 8'h69, ALU_SW    = 8'h6B,
        ALU_BLTZ  = 8'h80, ALU_BGEZ  = 8'h81
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110,
        SEL_LOAD_STORE  = 3'b111
    } alusel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JUMP, BR_JUMP_REG, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
    } br_kind_e;

    typedef struct packed {
        aluop_e                aluop;
        alusel_e               alusel;
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
        logic                  re1;
        logic                  re2;
        logic [REG_ADDR_W-1:0] raddr1;
        logic [REG_ADDR_W-1:0] raddr2;
        logic [XLEN-1:0]       imm;
        br_kind_e              br_kind;
        logic                  link;
    } dec_ctrl_t;

    typedef struct packed {
        logic                  wreg;
        logic [REG_ADDR_W-1:0] wd;
        logic [XLEN-1:0]       wdata;
    } fwd_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_t;

    typedef struct packed {
        aluop_e                aluop;
        alusel_e               alusel;
        logic [XLEN-1:0]       reg1;
        logic [XLEN-1:0]       reg2;
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
        logic [XLEN-1:0]       link_addr;
        logic [XLEN-1:0]       inst;
    } id_ex_t;

    localparam id_ex_t ID_EX_BUBBLE = '{aluop: ALU_NOP, alusel: SEL_NOP, default: '0};

endpackage

`default_nettype wire

// ==== design/decode/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import id_pkg::*; (
    input  wire logic [XLEN-1:0] inst_i,
    output dec_ctrl_t            ctrl_o
);

    opcode_e               op;
    funct_e                fn;
    regimm_e               ri;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [7:0]            field_op;
    logic [XLEN-1:0]       imm_sext;
    logic [XLEN-1:0]       imm_zext;
    logic [XLEN-1:0]       imm_upper;
    logic [XLEN-1:0]       imm_sa;

    assign op = opcode_e'(inst_i[31:26]);
    assign fn = funct_e'(inst_i[5:0]);
    assign ri = regimm_e'(inst_i[20:16]);
    assign rs = inst_i[25:21];
    assign rt = inst_i[20:16];
    assign rd = inst_i[15:11];

    assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext  = {16'h0000, inst_i[15:0]};
    assign imm_upper = {inst_i[15:0], 16'h0000};
    assign imm_sa    = {27'd0, inst_i[10:6]};

    // Raw operation code, only taken over for recognised instructions
    always_comb begin
        case (op)
            OP_SPECIAL: field_op = {2'b11, inst_i[5:0]};
            OP_REGIMM:  field_op = {3'b100, inst_i[20:16]};
            default:    field_op = {2'b01, inst_i[31:26]};
        endcase
    end

    always_comb begin
        ctrl_o = '0;
        ctrl_o.aluop = ALU_NOP;
        ctrl_o.alusel = SEL_NOP;
        ctrl_o.br_kind = BR_NONE;
        ctrl_o.raddr1 = rs;
        ctrl_o.raddr2 = rt;
        ctrl_o.wd = rd;
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_OR, FN_AND, FN_XOR, FN_NOR,
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                    FN_SLLV, FN_SRLV, FN_SRAV: begin
                        ctrl_o.aluop = aluop_e'(field_op);
                        ctrl_o.wreg = 1'b1;
                        ctrl_o.re1 = 1'b1;
                        ctrl_o.re2 = 1'b1;
                        if (fn inside {FN_OR, FN_AND, FN_XOR, FN_NOR}) begin
                            ctrl_o.alusel = SEL_LOGIC;
                        end else if (fn inside {FN_SLLV, FN_SRLV, FN_SRAV}) begin
                            ctrl_o.alusel = SEL_SHIFT;
                        end else begin
                            ctrl_o.alusel = SEL_ARITH;
                        end
                    end
                    // Shift amount travels as reg1
                    FN_SLL, FN_SRL, FN_SRA: begin
                        ctrl_o.aluop = aluop_e'(field_op);
                        ctrl_o.alusel = SEL_SHIFT;
                        ctrl_o.wreg = 1'b1;
                        ctrl_o.re2 = 1'b1;
                        ctrl_o.imm = imm_sa;
                    end
                    FN_JR, FN_JALR: begin
                        ctrl_o.aluop = aluop_e'(field_op);
                        ctrl_o.alusel = SEL_JUMP_BRANCH;
                        ctrl_o.re1 = 1'b1;
                        ctrl_o.br_kind = BR_JUMP_REG;
                        ctrl_o.wreg = (fn == FN_JALR);
                        ctrl_o.link = (fn == FN_JALR);
                    end
                    default: begin
                    end
                endcase
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl_o.aluop = aluop_e'(field_op);
                ctrl_o.alusel = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU} ?
                    SEL_ARITH : SEL_LOAD_STORE;
                ctrl_o.wreg = 1'b1;
                ctrl_o.wd = rt;
                ctrl_o.re1 = 1'b1;
                ctrl_o.imm = imm_sext;
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl_o.aluop = aluop_e'(field_op);
                ctrl_o.alusel = SEL_LOAD_STORE;
                ctrl_o.re1 = 1'b1;
                ctrl_o.re2 = 1'b1;
                ctrl_o.imm = imm_sext;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl_o.aluop = aluop_e'(field_op);
                ctrl_o.alusel = SEL_LOGIC;
                ctrl_o.wreg = 1'b1;
                ctrl_o.wd = rt;
                ctrl_o.re1 = 1'b1;
                ctrl_o.imm = (op == OP_LUI) ? imm_upper : imm_zext;
            end
            OP_J, OP_JAL: begin
                ctrl_o.aluop = aluop_e'(field_op);
                ctrl_o.alusel = SEL_JUMP_BRANCH;
                ctrl_o.br_kind = BR_JUMP;
                ctrl_o.wd = LINK_REG;
                ctrl_o.wreg = (op == OP_JAL);
                ctrl_o.link = (op == OP_JAL);
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                ctrl_o.aluop = aluop_e'(field_op);
                ctrl_o.alusel = SEL_JUMP_BRANCH;
                ctrl_o.re1 = 1'b1;
                ctrl_o.re2 = op inside {OP_BEQ, OP_BNE};
                case (op)
                    OP_BEQ:  ctrl_o.br_kind = BR_EQ;
                    OP_BNE:  ctrl_o.br_kind = BR_NE;
                    OP_BLEZ: ctrl_o.br_kind = BR_LEZ;
                    default: ctrl_o.br_kind = BR_GTZ;
                endcase
            end
            OP_REGIMM: begin
                if (ri inside {RI_BLTZ, RI_BGEZ}) begin
                    ctrl_o.aluop = aluop_e'(field_op);
                    ctrl_o.alusel = SEL_JUMP_BRANCH;
                    ctrl_o.re1 = 1'b1;
                    ctrl_o.br_kind = (ri == RI_BLTZ) ? BR_LTZ : BR_GEZ;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/decode/operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch import id_pkg::*; (
    input  dec_ctrl_t            ctrl_i,
    input  wire logic [XLEN-1:0] rf_rdata1_i,
    input  wire logic [XLEN-1:0] rf_rdata2_i,
    input  id_ex_t               ex_prev_i,
    input  wire logic [XLEN-1:0] ex_wdata_i,
    input  fwd_t                 mem_fwd_i,
    output logic [XLEN-1:0]      reg1_o,
    output logic [XLEN-1:0]      reg2_o,
    output logic                 stall_o
);

    logic prev_is_load;
    logic load_hit1;
    logic load_hit2;

    // Execute result first, then memory, then the register file
    function automatic logic [XLEN-1:0] pick_operand(
        input logic                  re,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_data
    );
        if (!re) begin
            return ctrl_i.imm;
        end else if (ex_prev_i.wreg && (ex_prev_i.wd == addr)) begin
            return ex_wdata_i;
        end else if (mem_fwd_i.wreg && (mem_fwd_i.wd == addr)) begin
            return mem_fwd_i.wdata;
        end
        return rf_data;
    endfunction

    always_comb begin
        reg1_o = pick_operand(ctrl_i.re1, ctrl_i.raddr1, rf_rdata1_i);
        reg2_o = pick_operand(ctrl_i.re2, ctrl_i.raddr2, rf_rdata2_i);
    end

    // Load data only exists after the memory stage
    assign prev_is_load = ex_prev_i.aluop inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};
    assign load_hit1 = ctrl_i.re1 && (ex_prev_i.wd == ctrl_i.raddr1);
    assign load_hit2 = ctrl_i.re2 && (ex_prev_i.wd == ctrl_i.raddr2);
    assign stall_o = prev_is_load && (load_hit1 || load_hit2);

endmodule

`default_nettype wire

// ==== design/decode/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve import id_pkg::*; (
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic [XLEN-1:0] inst_i,
    input  br_kind_e             br_kind_i,
    input  wire logic [XLEN-1:0] reg1_i,
    input  wire logic [XLEN-1:0] reg2_i,
    output branch_t              branch_o,
    output logic [XLEN-1:0]      link_addr_o
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] br_offset;
    logic            reg1_zero;
    logic            reg1_neg;

    assign pc_plus4 = pc_i + XLEN'(4);
    assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign reg1_zero = (reg1_i == '0);
    assign reg1_neg = reg1_i[XLEN-1];

    // Return address skips the delay slot
    assign link_addr_o = pc_i + XLEN'(8);

    always_comb begin
        branch_o.taken = 1'b0;
        branch_o.target = pc_plus4 + br_offset;
        case (br_kind_i)
            BR_JUMP: begin
                branch_o.taken = 1'b1;
                branch_o.target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
            end
            BR_JUMP_REG: begin
                branch_o.taken = 1'b1;
                branch_o.target = reg1_i;
            end
            BR_EQ:   branch_o.taken = (reg1_i == reg2_i);
            BR_NE:   branch_o.taken = (reg1_i != reg2_i);
            BR_GTZ:  branch_o.taken = !reg1_neg && !reg1_zero;
            BR_LEZ:  branch_o.taken = reg1_neg || reg1_zero;
            BR_GEZ:  branch_o.taken = !reg1_neg;
            BR_LTZ:  branch_o.taken = reg1_neg;
            default: branch_o.taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import id_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n_i,
    input  wire logic            stall_i,
    input  dec_ctrl_t            ctrl_i,
    input  wire logic [XLEN-1:0] reg1_i,
    input  wire logic [XLEN-1:0] reg2_i,
    input  wire logic [XLEN-1:0] link_addr_i,
    input  wire logic [XLEN-1:0] inst_i,
    output id_ex_t               id_ex_o
);

    id_ex_t decoded;

    always_comb begin
        decoded.aluop = ctrl_i.aluop;
        decoded.alusel = ctrl_i.alusel;
        decoded.reg1 = reg1_i;
        decoded.reg2 = reg2_i;
        decoded.wd = ctrl_i.wd;
        decoded.wreg = ctrl_i.wreg;
        // Only linking jumps hand a return address to execute
        decoded.link_addr = ctrl_i.link ? link_addr_i : '0;
        decoded.inst = inst_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= ID_EX_BUBBLE;
        end else if (stall_i) begin
            id_ex_o <= ID_EX_BUBBLE;
        end else begin
            id_ex_o <= decoded;
        end
    end

endmodule

`default_nettype wire

// ==== design/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic [XLEN-1:0]       inst_i,
    input  wire logic [XLEN-1:0]       rf_rdata1_i,
    input  wire logic [XLEN-1:0]       rf_rdata2_i,
    input  wire logic [XLEN-1:0]       ex_wdata_i,
    input  fwd_t                       mem_fwd_i,
    output logic [REG_ADDR_W-1:0]      rf_raddr1_o,
    output logic [REG_ADDR_W-1:0]      rf_raddr2_o,
    output logic                       stall_o,
    output branch_t                    branch_o,
    output id_ex_t                     id_ex_o
);

    dec_ctrl_t       ctrl;
    logic [XLEN-1:0] reg1;
    logic [XLEN-1:0] reg2;
    logic [XLEN-1:0] link_addr;

    assign rf_raddr1_o = ctrl.raddr1;
    assign rf_raddr2_o = ctrl.raddr2;

    instr_decoder i_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    // ID/EX contents are the instruction now in execute
    operand_fetch i_operand_fetch (
        .ctrl_i      (ctrl),
        .rf_rdata1_i (rf_rdata1_i),
        .rf_rdata2_i (rf_rdata2_i),
        .ex_prev_i   (id_ex_o),
        .ex_wdata_i  (ex_wdata_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_o      (reg1),
        .reg2_o      (reg2),
        .stall_o     (stall_o)
    );

    branch_resolve i_branch_resolve (
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .br_kind_i   (ctrl.br_kind),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .branch_o    (branch_o),
        .link_addr_o (link_addr)
    );

    id_ex_reg i_id_ex_reg (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_o),
        .ctrl_i      (ctrl),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .link_addr_i (link_addr),
        .inst_i      (inst_i),
        .id_ex_o     (id_ex_o)
    );

endmodule

`default_nettype wire

// ==== verification/tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rf1;
        logic [31:0] rf2;
        logic [31:0] exw;
        fwd_t        mem;
        logic        stall;
        logic        taken;
        logic [31:0] target;
        aluop_e      aluop;
        logic        wreg;
        logic [4:0]  wd;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] link;
    } row_t;

    logic clk;
    logic rst_n_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic [31:0] rf_rdata1_i;
    logic [31:0] rf_rdata2_i;
    logic [31:0] ex_wdata_i;
    fwd_t mem_fwd_i;
    logic [4:0] rf_raddr1_o;
    logic [4:0] rf_raddr2_o;
    logic stall_o;
    branch_t branch_o;
    id_ex_t id_ex_o;

    row_t rows[$];
    integer seed = 80;
    logic [31:0] a, b, c, d;
    logic [31:0] pc_n, rf1, rf2, exw;
    fwd_t mem;

    id_stage i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .rf_rdata1_i (rf_rdata1_i),
        .rf_rdata2_i (rf_rdata2_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_fwd_i   (mem_fwd_i),
        .rf_raddr1_o (rf_raddr1_o),
        .rf_raddr2_o (rf_raddr2_o),
        .stall_o     (stall_o),
        .branch_o    (branch_o),
        .id_ex_o     (id_ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Result class of each kept instruction
    function automatic alusel_e expected_class(input aluop_e op);
        case (op)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR, ALU_ORI, ALU_ANDI, ALU_XORI, ALU_LUI:
                return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV:
                return SEL_SHIFT;
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
            ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU:
                return SEL_ARITH;
            ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_SB, ALU_SH, ALU_SW:
                return SEL_LOAD_STORE;
            ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ, ALU_BNE,
            ALU_BGTZ, ALU_BLEZ, ALU_BGEZ, ALU_BLTZ:
                return SEL_JUMP_BRANCH;
            default:
                return SEL_NOP;
        endcase
    endfunction

    task automatic add(input logic [31:0] inst, input logic stall, input logic taken,
                       input logic [31:0] target, input aluop_e op, input logic wreg,
                       input logic [4:0] wd, input logic [31:0] r1, input logic [31:0] r2,
                       input logic [31:0] link);
        rows.push_back('{pc_n, inst, rf1, rf2, exw, mem, stall, taken, target,
                         op, wreg, wd, r1, r2, link});
        // Upstream holds the PC while stalled
        if (!stall) begin
            pc_n = pc_n + 32'd4;
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bubble();
        check("id_ex_o.aluop", id_ex_o.aluop, ALU_NOP);
        check("id_ex_o.alusel", id_ex_o.alusel, SEL_NOP);
        check("id_ex_o.reg1", id_ex_o.reg1, 32'h0);
        check("id_ex_o.reg2", id_ex_o.reg2, 32'h0);
        check("id_ex_o.wd", id_ex_o.wd, 5'd0);
        check("id_ex_o.wreg", id_ex_o.wreg, 1'b0);
        check("id_ex_o.link_addr", id_ex_o.link_addr, 32'h0);
        check("id_ex_o.inst", id_ex_o.inst, 32'h0);
    endtask

    task automatic build_table();
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        d = $random(seed);
        pc_n = 32'h0000_1000;
        rf1 = a;
        rf2 = b;
        exw = 32'h0;
        mem = '0;
        add(rtype(1, 2, 3, 0, FN_ADDU), 0, 0, 0, ALU_ADDU, 1, 3, a, b, 0);
        add(itype(OP_ORI, 5, 4, 16'h8001), 0, 0, 0, ALU_ORI, 1, 4, a, 32'h8001, 0);
        add(itype(OP_ADDI, 7, 6, 16'hfff0), 0, 0, 0, ALU_ADDI, 1, 6, a, 32'hfffffff0, 0);
        add(itype(OP_LUI, 0, 8, 16'h1234), 0, 0, 0, ALU_LUI, 1, 8, a, 32'h12340000, 0);
        add(rtype(0, 10, 9, 5, FN_SRA), 0, 0, 0, ALU_SRA, 1, 9, 5, b, 0);
        // Execute beats memory on the same register
        exw = c;
        mem = '{1'b1, 5'd9, d};
        add(rtype(9, 12, 11, 0, FN_SUB), 0, 0, 0, ALU_SUB, 1, 11, c, b, 0);
        mem = '{1'b1, 5'd12, d};
        add(rtype(12, 14, 13, 0, FN_AND), 0, 0, 0, ALU_AND, 1, 13, d, b, 0);
        mem = '0;
        add(itype(OP_LB, 13, 14, 16'hff00), 0, 0, 0, ALU_LB, 1, 14, c, 32'hffffff00, 0);
        add(itype(OP_LW, 1, 15, 16'h0004), 0, 0, 0, ALU_LW, 1, 15, a, 4, 0);
        // Load-use: one stall, then the loaded value arrives from memory
        add(rtype(15, 2, 16, 0, FN_ADD), 1, 0, 0, ALU_NOP, 0, 0, 0, 0, 0);
        mem = '{1'b1, 5'd15, d};
        add(rtype(15, 2, 16, 0, FN_ADD), 0, 0, 0, ALU_ADD, 1, 16, d, b, 0);
        mem = '0;
        rf2 = a;
        add(itype(OP_BEQ, 17, 18, 16'h0010), 0, 1, pc_n + 32'h44, ALU_BEQ, 0, 0, a, a, 0);
        rf2 = a ^ 32'h1;
        add(itype(OP_BEQ, 17, 18, 16'h0010), 0, 0, 0, ALU_BEQ, 0, 0, a, rf2, 0);
        add(itype(OP_BNE, 17, 18, 16'hfffc), 0, 1, pc_n - 32'hc, ALU_BNE, 0, 31, a, rf2, 0);
        rf2 = a;
        add(itype(OP_BNE, 17, 18, 16'hfffc), 0, 0, 0, ALU_BNE, 0, 31, a, a, 0);
        rf1 = 32'd5;
        add(itype(OP_BGTZ, 19, 0, 16'h8), 0, 1, pc_n + 32'h24, ALU_BGTZ, 0, 0, 5, 0, 0);
        rf1 = 32'd0;
        add(itype(OP_BGTZ, 19, 0, 16'h8), 0, 0, 0, ALU_BGTZ, 0, 0, 0, 0, 0);
        add(itype(OP_BLEZ, 19, 0, 16'h8), 0, 1, pc_n + 32'h24, ALU_BLEZ, 0, 0, 0, 0, 0);
        rf1 = 32'd1;
        add(itype(OP_BLEZ, 19, 0, 16'h8), 0, 0, 0, ALU_BLEZ, 0, 0, 1, 0, 0);
        rf1 = 32'd0;
        add(itype(OP_REGIMM, 19, 1, 16'h8), 0, 1, pc_n + 32'h24, ALU_BGEZ, 0, 0, 0, 0, 0);
        rf1 = 32'h8000_0000;
        add(itype(OP_REGIMM, 19, 1, 16'h8), 0, 0, 0, ALU_BGEZ, 0, 0, rf1, 0, 0);
        add(itype(OP_REGIMM, 19, 0, 16'h8), 0, 1, pc_n + 32'h24, ALU_BLTZ, 0, 0, rf1, 0, 0);
        rf1 = 32'd7;
        add(itype(OP_REGIMM, 19, 0, 16'h8), 0, 0, 0, ALU_BLTZ, 0, 0, 7, 0, 0);
        // Jumps inside the 0x4 region
        pc_n = 32'h4000_0100;
        add({OP_J, 26'h0123456}, 0, 1, 32'h4048_d158, ALU_J, 0, 31, 0, 0, 0);
        add({OP_JAL, 26'h0123456}, 0, 1, 32'h4048_d158, ALU_JAL, 1, 31, 0, 0, pc_n + 32'd8);
        rf1 = a;
        add(rtype(20, 0, 0, 0, FN_JR), 0, 1, a, ALU_JR, 0, 0, a, 0, 0);
        rf1 = b;
        add(rtype(21, 0, 22, 0, FN_JALR), 0, 1, b, ALU_JALR, 1, 22, b, 0, pc_n + 32'd8);
        rf1 = a;
        rf2 = b;
        add(rtype(24, 25, 23, 0, FN_SLTU), 0, 0, 0, ALU_SLTU, 1, 23, a, b, 0);
        add(rtype(27, 28, 26, 0, FN_NOR), 0, 0, 0, ALU_NOR, 1, 26, a, b, 0);
        add(rtype(10, 11, 12, 0, FN_XOR), 0, 0, 0, ALU_XOR, 1, 12, a, b, 0);
        add(rtype(1, 2, 29, 0, FN_SRLV), 0, 0, 0, ALU_SRLV, 1, 29, a, b, 0);
        add(itype(OP_ANDI, 3, 30, 16'hf0f0), 0, 0, 0, ALU_ANDI, 1, 30, a, 32'hf0f0, 0);
        add(itype(OP_SLTIU, 4, 5, 16'h8000), 0, 0, 0, ALU_SLTIU, 1, 5, a, 32'hffff8000, 0);
        add(itype(OP_SW, 6, 7, 16'h0008), 0, 0, 0, ALU_SW, 0, 0, a, b, 0);
        add(rtype(0, 9, 8, 31, FN_SLL), 0, 0, 0, ALU_SLL, 1, 8, 31, b, 0);
        add(rtype(1, 2, 3, 0, FN_OR), 0, 0, 0, ALU_OR, 1, 3, a, b, 0);
        add(rtype(4, 5, 6, 0, FN_SUBU), 0, 0, 0, ALU_SUBU, 1, 6, a, b, 0);
        add(rtype(7, 9, 10, 0, FN_SLT), 0, 0, 0, ALU_SLT, 1, 10, a, b, 0);
        add(rtype(0, 11, 12, 3, FN_SRL), 0, 0, 0, ALU_SRL, 1, 12, 3, b, 0);
        add(rtype(13, 14, 15, 0, FN_SLLV), 0, 0, 0, ALU_SLLV, 1, 15, a, b, 0);
        add(rtype(16, 17, 18, 0, FN_SRAV), 0, 0, 0, ALU_SRAV, 1, 18, a, b, 0);
        add(itype(OP_XORI, 19, 20, 16'h8421), 0, 0, 0, ALU_XORI, 1, 20, a, 32'h8421, 0);
        add(itype(OP_ADDIU, 21, 22, 16'h8000), 0, 0, 0, ALU_ADDIU, 1, 22, a, 32'hffff8000, 0);
        add(itype(OP_SLTI, 23, 24, 16'h7fff), 0, 0, 0, ALU_SLTI, 1, 24, a, 32'h7fff, 0);
        add(itype(OP_LBU, 25, 26, 16'h0001), 0, 0, 0, ALU_LBU, 1, 26, a, 1, 0);
        add(itype(OP_LH, 27, 28, 16'hfffe), 0, 0, 0, ALU_LH, 1, 28, a, 32'hfffffffe, 0);
        add(itype(OP_LHU, 29, 30, 16'h0002), 0, 0, 0, ALU_LHU, 1, 30, a, 2, 0);
        add(itype(OP_SB, 1, 2, 16'h0003), 0, 0, 0, ALU_SB, 0, 0, a, b, 0);
        add(itype(OP_SH, 3, 4, 16'h0006), 0, 0, 0, ALU_SH, 0, 0, a, b, 0);
    endtask

    task automatic check_id_ex(input row_t r);
        if (r.stall) begin
            check_bubble();
        end else begin
            check("id_ex_o.aluop", id_ex_o.aluop, r.aluop);
            check("id_ex_o.alusel", id_ex_o.alusel, expected_class(r.aluop));
            check("id_ex_o.wreg", id_ex_o.wreg, r.wreg);
            check("id_ex_o.wd", id_ex_o.wd, r.wd);
            check("id_ex_o.reg1", id_ex_o.reg1, r.r1);
            check("id_ex_o.reg2", id_ex_o.reg2, r.r2);
            check("id_ex_o.link_addr", id_ex_o.link_addr, r.link);
            check("id_ex_o.inst", id_ex_o.inst, r.inst);
        end
    endtask

    initial begin
        rst_n_i <= 1'b0;
        pc_i <= '0;
        inst_i <= '0;
        rf_rdata1_i <= '0;
        rf_rdata2_i <= '0;
        ex_wdata_i <= '0;
        mem_fwd_i <= '0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_bubble();
        check("stall_o", stall_o, 1'b0);
        check("branch_o.taken", branch_o.taken, 1'b0);
        @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                pc_i <= rows[i].pc;
                inst_i <= rows[i].inst;
                rf_rdata1_i <= rows[i].rf1;
                rf_rdata2_i <= rows[i].rf2;
                ex_wdata_i <= rows[i].exw;
                mem_fwd_i <= rows[i].mem;
            end
            @(negedge clk);
            if (i > 0) begin
                check_id_ex(rows[i-1]);
            end
            if (i < rows.size()) begin
                // Read indices are the rs and rt fields
                check("rf_raddr1_o", rf_raddr1_o, rows[i].inst[25:21]);
                check("rf_raddr2_o", rf_raddr2_o, rows[i].inst[20:16]);
                check("stall_o", stall_o, rows[i].stall);
                check("branch_o.taken", branch_o.taken, rows[i].taken);
                if (rows[i].taken) begin
                    check("branch_o.target", branch_o.target, rows[i].target);
                end
            end
        end
        $display("Simulation passed");
        $finish;
    end

    // Four clock periods per row plus reset
    initial begin
        #1;
        #((rows.size() * 4 + 12) * 100);
        $display("Timeout before all table rows were applied");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== id_stage.f ====
common/id_pkg.sv
design/decode/instr_decoder.sv
design/decode/operand_fetch.sv
design/decode/branch_resolve.sv
design/id_ex_reg.sv
design/id_stage.sv
verification/tb_id_stage.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_id_stage
RTL_TOP    ?= id_stage
FILELIST   ?= id_stage.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)
